//--- verilog/expander_config.svh
// ######################################
// SCL divider and PCAL6416A register pointers
// ######################################

`ifndef EXPANDER_CONFIG_SVH
`define EXPANDER_CONFIG_SVH

// clk cycles per quarter of an SCL period
`define EXP_I2C_DIV 4

// expander register pointers
`define EXP_REG_INPUT    8'h00
`define EXP_REG_OUTPUT   8'h02
`define EXP_REG_CONFIG   8'h06
`define EXP_REG_INT_MASK 8'h4A

`endif

//--- verilog/expander_pkg.sv
// ######################################
// shared types for the PCAL6416A expander
// controller and its I2C engine
// ######################################

package expander_pkg;

    // one bit per expander pin, port 0 in the low byte
    typedef logic [15:0] port_word_t;
    typedef logic [7:0]  reg_byte_t;
    typedef logic [6:0]  dev_addr_t;
    typedef logic [1:0]  byte_count_t;

    // controller sequencing states
    typedef enum logic [3:0] {
        IDLE,
        INIT_CFG,
        INIT_CFG_WAIT,
        INIT_MASK,
        INIT_MASK_WAIT,
        UPDATE,
        WRITE,
        WRITE_WAIT,
        READ_PTR,
        READ_PTR_WAIT,
        READ_DATA,
        READ_DATA_WAIT
    } ctrl_state_t;

endpackage

//--- verilog/i2c_xfer_if.sv
// ######################################
// one I2C transaction descriptor with
// start and done strobes
// ######################################

interface i2c_xfer_if;
    import expander_pkg::*;

    logic        start;
    byte_count_t num_wr_bytes;
    reg_byte_t   wr_data0;
    reg_byte_t   wr_data1;
    reg_byte_t   wr_data2;
    byte_count_t num_rd_bytes;
    logic        done;
    reg_byte_t   rd_data0;
    reg_byte_t   rd_data1;

    modport controller (
        output start, num_wr_bytes, wr_data0, wr_data1, wr_data2, num_rd_bytes,
        input  done, rd_data0, rd_data1
    );

    modport engine (
        input  start, num_wr_bytes, wr_data0, wr_data1, wr_data2, num_rd_bytes,
        output done, rd_data0, rd_data1
    );

endinterface

//--- verilog/pcal6416a_ctrl.sv
// ######################################
// PCAL6416A controller FSM
// sequences init, read and write register
// transactions over the I2C engine
// ######################################

`include "expander_config.svh"

module pcal6416a_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  expander_pkg::port_word_t out_data,
    input  expander_pkg::port_word_t input_mask,
    input  logic                   read,
    input  logic                   write,
    input  logic                   start,
    input  logic                   start_init,
    output expander_pkg::port_word_t in_data,
    output logic                   in_valid,
    output logic                   done,
    i2c_xfer_if.controller         xfer
);
    import expander_pkg::*;

    ctrl_state_t state;

    // requests still to be served by UPDATE
    logic pending_read;
    logic pending_write;

    // descriptor and payload, held until the engine reports done
    always_ff @(posedge clk) begin
        if (enable) begin
            case (state)
                INIT_CFG: begin
                    xfer.num_wr_bytes <= 2'd3;
                    xfer.num_rd_bytes <= 2'd0;
                    xfer.wr_data0     <= `EXP_REG_CONFIG;
                    xfer.wr_data1     <= input_mask[7:0];
                    xfer.wr_data2     <= input_mask[15:8];
                end
                INIT_MASK: begin
                    // pins used as inputs may interrupt, the rest are masked
                    xfer.num_wr_bytes <= 2'd3;
                    xfer.num_rd_bytes <= 2'd0;
                    xfer.wr_data0     <= `EXP_REG_INT_MASK;
                    xfer.wr_data1     <= ~input_mask[7:0];
                    xfer.wr_data2     <= ~input_mask[15:8];
                end
                WRITE: begin
                    xfer.num_wr_bytes <= 2'd3;
                    xfer.num_rd_bytes <= 2'd0;
                    xfer.wr_data0     <= `EXP_REG_OUTPUT;
                    xfer.wr_data1     <= out_data[7:0];
                    xfer.wr_data2     <= out_data[15:8];
                end
                READ_PTR: begin
                    xfer.num_wr_bytes <= 2'd1;
                    xfer.num_rd_bytes <= 2'd0;
                    xfer.wr_data0     <= `EXP_REG_INPUT;
                end
                READ_DATA: begin
                    // pointer already set, plain two byte read
                    xfer.num_wr_bytes <= 2'd0;
                    xfer.num_rd_bytes <= 2'd2;
                end
                READ_DATA_WAIT: begin
                    if (xfer.done) begin
                        in_data <= {xfer.rd_data1, xfer.rd_data0};
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= IDLE;
            pending_read  <= 1'b0;
            pending_write <= 1'b0;
            done          <= 1'b0;
            in_valid      <= 1'b0;
            xfer.start    <= 1'b0;
        end else begin
            in_valid <= 1'b0;

            if (enable) begin
                xfer.start <= 1'b0;

                case (state)
                    IDLE: begin
                        done <= 1'b1;
                        if (start_init) begin
                            done  <= 1'b0;
                            state <= INIT_CFG;
                        end else if (start) begin
                            pending_read  <= read;
                            pending_write <= write;
                            done          <= 1'b0;
                            state         <= UPDATE;
                        end
                    end

                    INIT_CFG: begin
                        xfer.start <= 1'b1;
                        state      <= INIT_CFG_WAIT;
                    end
                    INIT_CFG_WAIT: begin
                        if (xfer.done) begin
                            state <= INIT_MASK;
                        end
                    end
                    INIT_MASK: begin
                        xfer.start <= 1'b1;
                        state      <= INIT_MASK_WAIT;
                    end
                    INIT_MASK_WAIT: begin
                        // bring inputs and outputs in line after init
                        if (xfer.done) begin
                            pending_read  <= 1'b1;
                            pending_write <= 1'b1;
                            state         <= UPDATE;
                        end
                    end

                    UPDATE: begin
                        if (pending_read) begin
                            state <= READ_PTR;
                        end else if (pending_write) begin
                            state <= WRITE;
                        end else begin
                            state <= IDLE;
                        end
                    end

                    WRITE: begin
                        xfer.start <= 1'b1;
                        state      <= WRITE_WAIT;
                    end
                    WRITE_WAIT: begin
                        if (xfer.done) begin
                            pending_write <= 1'b0;
                            state         <= UPDATE;
                        end
                    end

                    READ_PTR: begin
                        xfer.start <= 1'b1;
                        state      <= READ_PTR_WAIT;
                    end
                    READ_PTR_WAIT: begin
                        if (xfer.done) begin
                            state <= READ_DATA;
                        end
                    end
                    READ_DATA: begin
                        xfer.start <= 1'b1;
                        state      <= READ_DATA_WAIT;
                    end
                    READ_DATA_WAIT: begin
                        if (xfer.done) begin
                            pending_read <= 1'b0;
                            in_valid     <= 1'b1;
                            state        <= UPDATE;
                        end
                    end

                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

endmodule

//--- verilog/i2c_basic.sv
// ######################################
// bit-level I2C master, start, address,
// data bytes and stop on open-drain lines
// ######################################

`include "expander_config.svh"

module i2c_basic (
    input  logic                  clk,
    input  logic                  reset,
    input  expander_pkg::dev_addr_t addr,
    input  logic                  scl_in,
    input  logic                  sda_in,
    output logic                  scl_oe,
    output logic                  sda_oe,
    i2c_xfer_if.engine            xfer
);
    import expander_pkg::*;

    localparam int CNT_W = $clog2(`EXP_I2C_DIV + 1);

    typedef enum logic [2:0] {
        PH_IDLE,
        PH_START,
        PH_BIT,
        PH_ACK,
        PH_STOP
    } phase_t;

    phase_t      phase;
    logic [CNT_W-1:0] div_cnt;
    logic        tick;
    logic [1:0]  quarter;
    logic [2:0]  bit_cnt;
    // 0 is the address byte, then data bytes 1 to 3
    byte_count_t byte_idx;
    reg_byte_t   rx_shift;

    logic        rd_mode;
    logic        rx_byte;
    logic        last_byte;
    byte_count_t n_bytes;
    reg_byte_t   tx_byte;

    assign tick = (div_cnt == CNT_W'(`EXP_I2C_DIV - 1));

    // a transaction either writes or reads, never both
    assign rd_mode   = (xfer.num_rd_bytes != 2'd0);
    assign n_bytes   = rd_mode ? xfer.num_rd_bytes : xfer.num_wr_bytes;
    assign last_byte = (byte_idx == n_bytes);
    assign rx_byte   = rd_mode && (byte_idx != 2'd0);

    always_comb begin
        case (byte_idx)
            2'd0:    tx_byte = {addr, rd_mode};
            2'd1:    tx_byte = xfer.wr_data0;
            2'd2:    tx_byte = xfer.wr_data1;
            default: tx_byte = xfer.wr_data2;
        endcase
    end

    // line drive per phase and quarter, scl high in quarters 1 and 2
    always_comb begin
        scl_oe = 1'b0;
        sda_oe = 1'b0;
        case (phase)
            PH_START: begin
                scl_oe = (quarter == 2'd3);
                sda_oe = quarter[1];
            end
            PH_BIT: begin
                scl_oe = (quarter == 2'd0) || (quarter == 2'd3);
                sda_oe = !rx_byte && !tx_byte[bit_cnt];
            end
            PH_ACK: begin
                // master acks every read byte except the last one
                scl_oe = (quarter == 2'd0) || (quarter == 2'd3);
                sda_oe = rx_byte && !last_byte;
            end
            PH_STOP: begin
                scl_oe = (quarter == 2'd0);
                sda_oe = !quarter[1];
            end
            default: begin
            end
        endcase
    end

    // read data sampled mid SCL high
    always_ff @(posedge clk) begin
        if (phase == PH_BIT && tick && quarter == 2'd1 && rx_byte && scl_in) begin
            rx_shift <= {rx_shift[6:0], sda_in};
        end
        if (phase == PH_ACK && tick && quarter == 2'd3) begin
            if (rx_byte && byte_idx == 2'd1) begin
                xfer.rd_data0 <= rx_shift;
            end
            if (rx_byte && byte_idx == 2'd2) begin
                xfer.rd_data1 <= rx_shift;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= PH_IDLE;
            div_cnt   <= '0;
            quarter   <= 2'd0;
            bit_cnt   <= 3'd7;
            byte_idx  <= 2'd0;
            xfer.done <= 1'b0;
        end else begin
            xfer.done <= 1'b0;

            if (phase == PH_IDLE) begin
                div_cnt <= '0;
                quarter <= 2'd0;
                if (xfer.start) begin
                    phase    <= PH_START;
                    bit_cnt  <= 3'd7;
                    byte_idx <= 2'd0;
                end
            end else begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;

                if (tick) begin
                    quarter <= quarter + 2'd1;

                    if (quarter == 2'd3) begin
                        case (phase)
                            PH_START: begin
                                phase <= PH_BIT;
                            end
                            PH_BIT: begin
                                // MSB first
                                if (bit_cnt == 3'd0) begin
                                    phase <= PH_ACK;
                                end else begin
                                    bit_cnt <= bit_cnt - 3'd1;
                                end
                            end
                            PH_ACK: begin
                                // target ack is not checked
                                bit_cnt <= 3'd7;
                                if (last_byte) begin
                                    phase <= PH_STOP;
                                end else begin
                                    byte_idx <= byte_idx + 2'd1;
                                    phase    <= PH_BIT;
                                end
                            end
                            PH_STOP: begin
                                phase     <= PH_IDLE;
                                xfer.done <= 1'b1;
                            end
                            default: begin
                                phase <= PH_IDLE;
                            end
                        endcase
                    end
                end
            end
        end
    end

endmodule

//--- verilog/expander_top.sv
// ######################################
// PCAL6416A expander top, controller and
// I2C engine joined by a transaction bus
// ######################################

module expander_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   enable,
    input  logic                   start,
    input  logic                   start_init,
    input  logic                   read,
    input  logic                   write,
    input  expander_pkg::port_word_t out_data,
    input  expander_pkg::port_word_t input_mask,
    input  expander_pkg::dev_addr_t  addr,
    input  logic                   scl_in,
    input  logic                   sda_in,
    output expander_pkg::port_word_t in_data,
    output logic                   in_valid,
    output logic                   done,
    output logic                   scl_oe,
    output logic                   sda_oe
);

    i2c_xfer_if xfer ();

    pcal6416a_ctrl ctrl0 (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .out_data   (out_data),
        .input_mask (input_mask),
        .read       (read),
        .write      (write),
        .start      (start),
        .start_init (start_init),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .done       (done),
        .xfer       (xfer.controller)
    );

    // open-drain lines, oe high pulls low
    i2c_basic i2c0 (
        .clk    (clk),
        .reset  (reset),
        .addr   (addr),
        .scl_in (scl_in),
        .sda_in (sda_in),
        .scl_oe (scl_oe),
        .sda_oe (sda_oe),
        .xfer   (xfer.engine)
    );

endmodule

//--- test/tb_clock.sv
// ######################################
// free running 20 ns testbench clock
// ######################################

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

//--- test/pcal6416a_model.sv
// ######################################
// behavioral PCAL6416A I2C target with
// register file and input pins
// ######################################

`include "expander_config.svh"

module pcal6416a_model #(
    parameter expander_pkg::dev_addr_t DEV_ADDR = 7'h20
) (
    input  logic                     scl,
    input  logic                     sda,
    input  expander_pkg::port_word_t pins,
    output logic                     sda_oe,
    output expander_pkg::port_word_t config_reg,
    output expander_pkg::port_word_t int_mask_reg,
    output expander_pkg::port_word_t output_reg
);
    timeunit 1ns;
    timeprecision 100ps;
    import expander_pkg::*;

    reg_byte_t  shift;
    reg_byte_t  tx;
    // register pointer, toggles within a register pair
    reg_byte_t  cur;
    port_word_t rword;
    int         bit_n;
    int         byte_n;
    logic       active;
    logic       matched;
    logic       rd;
    logic       nacked;

    initial begin
        sda_oe       = 1'b0;
        active       = 1'b0;
        matched      = 1'b0;
        rd           = 1'b0;
        nacked       = 1'b0;
        cur          = 8'h00;
        // power-on values, all pins inputs and masked
        config_reg   = 16'hffff;
        int_mask_reg = 16'hffff;
        output_reg   = 16'hffff;
    end

    function automatic port_word_t reg_pair(input reg_byte_t ptr);
        case ({ptr[7:1], 1'b0})
            `EXP_REG_INPUT:    return pins;
            `EXP_REG_OUTPUT:   return output_reg;
            `EXP_REG_CONFIG:   return config_reg;
            `EXP_REG_INT_MASK: return int_mask_reg;
            default:           return 16'h0000;
        endcase
    endfunction

    task automatic write_reg(input reg_byte_t ptr, input reg_byte_t data);
        port_word_t word;
        word = reg_pair(ptr);
        if (ptr[0]) begin
            word[15:8] = data;
        end else begin
            word[7:0] = data;
        end
        case ({ptr[7:1], 1'b0})
            `EXP_REG_OUTPUT:   output_reg   = word;
            `EXP_REG_CONFIG:   config_reg   = word;
            `EXP_REG_INT_MASK: int_mask_reg = word;
            default: begin
            end
        endcase
    endtask

    // start condition
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active  = 1'b1;
            matched = 1'b0;
            rd      = 1'b0;
            nacked  = 1'b0;
            bit_n   = 0;
            byte_n  = 0;
        end
    end

    // stop condition
    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active = 1'b0;
            sda_oe = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (bit_n == 8) begin
                // master nack ends a read
                if (rd && byte_n > 0 && sda) begin
                    nacked = 1'b1;
                end
                bit_n  = 0;
                byte_n = byte_n + 1;
            end else begin
                shift = {shift[6:0], sda};
                bit_n = bit_n + 1;
            end
        end
    end

    // SDA only moves while SCL is low
    always @(negedge scl) begin
        if (active) begin
            sda_oe = 1'b0;
            if (rd && byte_n > 0) begin
                if (bit_n < 8 && matched && !nacked) begin
                    if (bit_n == 0) begin
                        rword = reg_pair(cur);
                        tx    = cur[0] ? rword[15:8] : rword[7:0];
                        cur   = cur ^ 8'h01;
                    end
                    sda_oe = !tx[7 - bit_n];
                end
            end else if (bit_n == 8) begin
                if (byte_n == 0) begin
                    matched = (shift[7:1] == DEV_ADDR);
                    rd      = shift[0];
                end else if (matched && byte_n == 1) begin
                    cur = shift;
                end else if (matched) begin
                    write_reg(cur, shift);
                    cur = cur ^ 8'h01;
                end
                sda_oe = matched;
            end
        end
    end

endmodule

//--- test/expander_props.sv
// ######################################
// bound checks on the I2C lines and the
// controller to engine handshake
// ######################################

module expander_props (
    input logic                      clk,
    input logic                      reset,
    input logic                      scl,
    input logic                      sda,
    input logic                      xfer_start,
    input logic                      xfer_done,
    input logic [2:0]                phase,
    input logic                      in_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    // engine phases where SDA may move with SCL high
    localparam logic [2:0] PHASE_START = 3'd1;
    localparam logic [2:0] PHASE_STOP  = 3'd4;

    int   fail_count = 0;
    logic busy;

    // a transaction is in flight from start until done
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (xfer_start) begin
            busy <= 1'b1;
        end else if (xfer_done) begin
            busy <= 1'b0;
        end
    end

    start_when_idle: assert property (@(posedge clk) disable iff (reset)
        xfer_start |-> !busy)
        else begin
            fail_count++;
            $error("start raised while a transaction was in flight");
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (reset)
        xfer_done |=> !xfer_done)
        else begin
            fail_count++;
            $error("engine done held high for more than one cycle");
        end

    sda_stable_scl_high: assert property (@(posedge clk) disable iff (reset)
        (scl && $past(scl) && $changed(sda)) |-> (phase == PHASE_START || phase == PHASE_STOP))
        else begin
            fail_count++;
            $error("SDA changed while SCL was high outside start or stop");
        end

    valid_low_in_reset: assert property (@(posedge clk)
        reset |=> !in_valid)
        else begin
            fail_count++;
            $error("in_valid high after a reset cycle");
        end

endmodule

bind expander_top expander_props props0 (
    .clk        (clk),
    .reset      (reset),
    .scl        (scl_in),
    .sda        (sda_in),
    .xfer_start (xfer.start),
    .xfer_done  (xfer.done),
    .phase      (i2c0.phase),
    .in_valid   (in_valid)
);

//--- test/expander_tb.sv
// ######################################
// testbench for the expander controller
// with I2C target model and checks
// ######################################

`include "expander_config.svh"

module expander_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import expander_pkg::*;

    localparam dev_addr_t DEV_ADDR    = 7'h20;
    localparam int        HOLD_CYCLES = 50;
    // 8 requests of 2 transactions, 40 bits of 4 quarters each
    localparam int TIMEOUT_CYCLES = 8 * 2 * 40 * 4 * `EXP_I2C_DIV + HOLD_CYCLES + 500;

    logic       clk;
    logic       reset;
    logic       enable;
    logic       start;
    logic       start_init;
    logic       read;
    logic       write;
    port_word_t out_data;
    port_word_t input_mask;
    dev_addr_t  addr;
    port_word_t in_data;
    logic       in_valid;
    logic       done;
    logic       scl_oe;
    logic       sda_oe;
    logic       model_sda_oe;
    logic       scl_line;
    logic       sda_line;
    port_word_t pins;
    port_word_t config_reg;
    port_word_t int_mask_reg;
    port_word_t output_reg;

    // request history for the reference
    port_word_t last_mask;
    port_word_t last_out;

    int    seed;
    int    cycles      = 0;
    int    valid_count = 0;
    int    valid_before;
    string test_name   = "reset";

    // open-drain lines, wired-AND with the target
    assign scl_line = !scl_oe;
    assign sda_line = !(sda_oe || model_sda_oe);

    tb_clock clk0 (
        .clk (clk)
    );

    expander_top dut0 (
        .clk        (clk),
        .reset      (reset),
        .enable     (enable),
        .start      (start),
        .start_init (start_init),
        .read       (read),
        .write      (write),
        .out_data   (out_data),
        .input_mask (input_mask),
        .addr       (addr),
        .scl_in     (scl_line),
        .sda_in     (sda_line),
        .in_data    (in_data),
        .in_valid   (in_valid),
        .done       (done),
        .scl_oe     (scl_oe),
        .sda_oe     (sda_oe)
    );

    pcal6416a_model #(.DEV_ADDR(DEV_ADDR)) exp0 (
        .scl          (scl_line),
        .sda          (sda_line),
        .pins         (pins),
        .sda_oe       (model_sda_oe),
        .config_reg   (config_reg),
        .int_mask_reg (int_mask_reg),
        .output_reg   (output_reg)
    );

    function automatic port_word_t expected_reg_value(input reg_byte_t ptr);
        case (ptr)
            `EXP_REG_CONFIG:   return last_mask;
            `EXP_REG_INT_MASK: return ~last_mask;
            `EXP_REG_OUTPUT:   return last_out;
            `EXP_REG_INPUT:    return pins;
            default:           return 16'h0000;
        endcase
    endfunction

    task automatic report_error(input string reason);
        $display("ERROR %s", reason);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_port(input string name, input port_word_t expected,
                              input port_word_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "port word mismatch");
        end
    endtask

    task automatic check_byte(input string name, input reg_byte_t expected,
                              input reg_byte_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "register byte mismatch");
        end
    endtask

    // low and high byte apart, each lands in its own register
    task automatic check_output(input string name);
        port_word_t expected;
        expected = expected_reg_value(`EXP_REG_OUTPUT);
        check_byte({name, " output low"}, expected[7:0], output_reg[7:0]);
        check_byte({name, " output high"}, expected[15:8], output_reg[15:8]);
    endtask

    task automatic check_pulses(input string name, input int expected);
        int actual;
        actual = valid_count - valid_before;
        if (actual != expected) begin
            $display("FAIL %s in_valid pulses: expected %0d, actual %0d",
                     name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "in_valid pulse count mismatch");
        end
    endtask

    task automatic wait_done();
        while (done !== 1'b1) begin
            @(negedge clk);
        end
    endtask

    task automatic run_request(input string name, input logic do_init,
                               input logic do_read, input logic do_write);
        test_name    = name;
        valid_before = valid_count;
        if (do_init) begin
            last_mask = input_mask;
            last_out  = out_data;
        end else if (do_write) begin
            last_out = out_data;
        end
        @(negedge clk);
        start_init = do_init;
        start      = !do_init;
        read       = do_read;
        write      = do_write;
        @(negedge clk);
        start_init = 1'b0;
        start      = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        if (done !== 1'b0) begin
            report_error({"done did not fall after the ", name, " request"});
        end
        wait_done();
    endtask

    // every in_valid pulse must carry the pins the target presents
    always @(negedge clk) begin
        if (!reset && in_valid === 1'b1) begin
            valid_count = valid_count + 1;
            check_port({test_name, " in_data"}, expected_reg_value(`EXP_REG_INPUT), in_data);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Simulation FAILED");
            $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    initial begin
        seed       = 32'h23a0;
        reset      = 1'b1;
        enable     = 1'b1;
        start      = 1'b0;
        start_init = 1'b0;
        read       = 1'b0;
        write      = 1'b0;
        addr       = DEV_ADDR;
        input_mask = 16'hf00f;
        out_data   = port_word_t'($random(seed));
        pins       = port_word_t'($random(seed));
        last_mask  = 16'h0000;
        last_out   = 16'hffff;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        wait_done();

        run_request("init", 1'b1, 1'b0, 1'b0);
        check_port("init config", expected_reg_value(`EXP_REG_CONFIG), config_reg);
        check_port("init int mask", expected_reg_value(`EXP_REG_INT_MASK), int_mask_reg);
        check_output("init");
        check_pulses("init", 1);

        out_data = port_word_t'($random(seed));
        run_request("write", 1'b0, 1'b0, 1'b1);
        check_output("write");
        check_pulses("write", 0);

        pins = port_word_t'($random(seed));
        run_request("read", 1'b0, 1'b1, 1'b0);
        check_output("read");
        check_pulses("read", 1);

        pins     = port_word_t'($random(seed));
        out_data = port_word_t'($random(seed));
        run_request("read write", 1'b0, 1'b1, 1'b1);
        check_output("read write");
        check_pulses("read write", 1);

        // request held while the controller is frozen
        test_name    = "enable low";
        pins         = port_word_t'($random(seed));
        out_data     = port_word_t'($random(seed));
        last_out     = out_data;
        valid_before = valid_count;
        @(negedge clk);
        enable = 1'b0;
        start  = 1'b1;
        read   = 1'b1;
        write  = 1'b1;
        repeat (HOLD_CYCLES) begin
            @(negedge clk);
            if (done !== 1'b1 || scl_oe !== 1'b0 || in_valid !== 1'b0) begin
                report_error("controller moved while enable was low");
            end
        end
        enable = 1'b1;
        @(negedge clk);
        start = 1'b0;
        read  = 1'b0;
        write = 1'b0;
        if (done !== 1'b0) begin
            report_error("done did not fall after enable returned high");
        end
        wait_done();
        check_output("enable low");
        check_pulses("enable low", 1);

        repeat (4) @(negedge clk);
        if (dut0.props0.fail_count != 0) begin
            $display("%0d bus or handshake assertions failed", dut0.props0.fail_count);
            $display("Simulation FAILED");
            $fatal(1, "assertion failures");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

//--- expander_top.f
+incdir+verilog
verilog/expander_pkg.sv
verilog/i2c_xfer_if.sv
verilog/pcal6416a_ctrl.sv
verilog/i2c_basic.sv
verilog/expander_top.sv
test/tb_clock.sv
test/pcal6416a_model.sv
test/expander_props.sv
test/expander_tb.sv
